// ==== verilog/zx_consts.svh ====
`ifndef ZX_CONSTS_SVH
`define ZX_CONSTS_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

`define ZX_ADDR_W 16
`define ZX_DATA_W 8
`define ZX_PAGE_W 8
`define ZX_WIN_W 2

//////////////////////////////////////////////////
// port map
//////////////////////////////////////////////////

// low byte shared by the extended ports
`define ZX_XT_PORT 8'hAF
// page registers at high bytes 10..13
`define ZX_XTPAGE_HI 8'h10
`define ZX_XTPAGE_MASK 8'hFC
`define ZX_MEMCONF_HI 8'h21

// beeper port, level on data bit 4
`define ZX_BEEP_PORT 8'hFE
`define ZX_BEEP_PORT_BIT 4
`define ZX_COVOX_PORT 8'hFB

// memconf fields
`define ZX_MEMCONF_W0_RAM 3
`define ZX_MEMCONF_W0_WE 1

// reset values
`define ZX_XTPAGE0_RST 8'h00
`define ZX_XTPAGE1_RST 8'h05
`define ZX_XTPAGE2_RST 8'h02
`define ZX_XTPAGE3_RST 8'h00
`define ZX_MEMCONF_RST 8'h00

`endif

// ==== verilog/zx_pkg.sv ====
`default_nettype none

`include "zx_consts.svh"

package zx_pkg;

	// cpu address and data
	typedef logic [`ZX_ADDR_W-1:0] zaddr_t;
	typedef logic [`ZX_DATA_W-1:0] zdata_t;

	// memory page number
	typedef logic [`ZX_PAGE_W-1:0] page_t;

	// one of four 16k windows
	typedef logic [`ZX_WIN_W-1:0] win_t;

	// synchronized bus state, mem is a memory read
	typedef enum logic [1:0] {
		CYC_IDLE,
		CYC_IORD,
		CYC_IOWR,
		CYC_MEM
	} bus_cycle_t;

endpackage

`default_nettype wire

// ==== verilog/zsignals.sv ====
`timescale 1ns/100ps
`default_nettype none

module zsignals import zx_pkg::*; (
	input  logic fclk,
	input  logic rst,

	input  logic iorq_n,
	input  logic mreq_n,
	input  logic rd_n,
	input  logic wr_n,

	output logic iowr_s,
	output logic iord,
	output logic memrd
);

	bus_cycle_t cycle_nxt;
	bus_cycle_t cycle;
	bus_cycle_t cycle_d;

	// raw strobes to cycle type
	always_comb begin
		cycle_nxt = CYC_IDLE;
		if (!iorq_n && !rd_n)
			cycle_nxt = CYC_IORD;
		else if (!iorq_n && !wr_n)
			cycle_nxt = CYC_IOWR;
		else if (!mreq_n && !rd_n)
			cycle_nxt = CYC_MEM;
	end

	always_ff @(posedge fclk) begin
		if (rst) begin
			cycle   <= CYC_IDLE;
			cycle_d <= CYC_IDLE;
			iowr_s  <= 1'b0;
		end else begin
			cycle   <= cycle_nxt;
			cycle_d <= cycle;
			// one pulse on entry to io write
			iowr_s  <= (cycle == CYC_IOWR) && (cycle_d != CYC_IOWR);
		end
	end

	assign iord  = (cycle == CYC_IORD);
	assign memrd = (cycle == CYC_MEM);

	assert property (@(posedge fclk) disable iff (rst) iowr_s |=> !iowr_s)
		else $error("iowr_s high two cycles in a row, cycle %s", cycle.name());

endmodule

`default_nettype wire

// ==== verilog/zports.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_consts.svh"

module zports import zx_pkg::*; (
	input  logic   fclk,
	input  logic   rst,

	input  zaddr_t a,
	input  zdata_t din,
	input  logic   iowr_s,
	input  logic   iord,

	output zdata_t dout,
	output logic   dout_en,

	output page_t  xt_page0,
	output page_t  xt_page1,
	output page_t  xt_page2,
	output page_t  xt_page3,
	output logic   w0_ram,
	output logic   w0_we,

	output logic   beep_level,
	output zdata_t covox_val,
	output logic   covox_sel
);

	page_t  xt_page [4];
	zdata_t memconf;

	logic   xt_hit;
	logic   page_hit;
	logic   memconf_hit;
	logic   beep_hit;
	logic   covox_hit;
	win_t   page_idx;
	zdata_t rd_mux;

	//////////////////////////////////////////////////
	// address decode
	//////////////////////////////////////////////////

	assign xt_hit      = (a[7:0] == `ZX_XT_PORT);
	assign page_hit    = xt_hit && ((a[15:8] & `ZX_XTPAGE_MASK) == `ZX_XTPAGE_HI);
	assign memconf_hit = xt_hit && (a[15:8] == `ZX_MEMCONF_HI);
	assign beep_hit    = (a[7:0] == `ZX_BEEP_PORT);
	assign covox_hit   = (a[7:0] == `ZX_COVOX_PORT);

	// which of the four page registers
	assign page_idx = a[9:8];

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge fclk) begin
		if (rst) begin
			xt_page[0] <= `ZX_XTPAGE0_RST;
			xt_page[1] <= `ZX_XTPAGE1_RST;
			xt_page[2] <= `ZX_XTPAGE2_RST;
			xt_page[3] <= `ZX_XTPAGE3_RST;
			memconf    <= `ZX_MEMCONF_RST;
			beep_level <= 1'b0;
			covox_val  <= '0;
			covox_sel  <= 1'b0;
		end else if (iowr_s) begin
			if (page_hit)
				xt_page[page_idx] <= din;
			if (memconf_hit)
				memconf <= din;
			// beeper write takes sound back from covox
			if (beep_hit) begin
				beep_level <= din[`ZX_BEEP_PORT_BIT];
				covox_sel  <= 1'b0;
			end
			if (covox_hit) begin
				covox_val <= din;
				covox_sel <= 1'b1;
			end
		end
	end

	assign xt_page0 = xt_page[0];
	assign xt_page1 = xt_page[1];
	assign xt_page2 = xt_page[2];
	assign xt_page3 = xt_page[3];

	assign w0_ram = memconf[`ZX_MEMCONF_W0_RAM];
	assign w0_we  = memconf[`ZX_MEMCONF_W0_WE];

	//////////////////////////////////////////////////
	// read back
	//////////////////////////////////////////////////

	assign rd_mux  = page_hit ? xt_page[page_idx] : memconf;
	assign dout_en = iord && (page_hit || memconf_hit);
	// bus stays quiet when nothing is read
	assign dout    = dout_en ? rd_mux : '0;

	assert property (@(posedge fclk) disable iff (rst) !(dout_en && iowr_s))
		else $error("port read enabled during a write strobe");

endmodule

`default_nettype wire

// ==== verilog/pager.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_consts.svh"

module pager import zx_pkg::*; (
	input  logic   fclk,
	input  logic   rst,

	input  zaddr_t a,
	input  page_t  xt_page0,
	input  page_t  xt_page1,
	input  page_t  xt_page2,
	input  page_t  xt_page3,
	input  logic   w0_ram,
	input  logic   w0_we,

	output page_t  page,
	output logic   romnram,
	output logic   rw_en
);

	win_t  win;
	page_t page_nxt;
	logic  romnram_nxt;
	logic  rw_en_nxt;

	// top address bits pick the window
	assign win = a[`ZX_ADDR_W-1 -: `ZX_WIN_W];

	always_comb begin
		case (win)
			2'd0:    page_nxt = xt_page0;
			2'd1:    page_nxt = xt_page1;
			2'd2:    page_nxt = xt_page2;
			default: page_nxt = xt_page3;
		endcase
	end

	// rom only in window 0, writes blocked there unless enabled
	assign romnram_nxt = (win == 2'd0) && !w0_ram;
	assign rw_en_nxt   = !(romnram_nxt && !w0_we);

	always_ff @(posedge fclk) begin
		page <= page_nxt;
		if (rst) begin
			romnram <= 1'b1;
			rw_en   <= 1'b0;
		end else begin
			romnram <= romnram_nxt;
			rw_en   <= rw_en_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sound.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_consts.svh"

module sound import zx_pkg::*; (
	input  logic   fclk,
	input  logic   rst,

	input  logic   beep_level,
	input  zdata_t covox_val,
	input  logic   covox_sel,

	output logic   beep
);

	zdata_t               acc;
	logic                 acc_carry;
	logic [`ZX_DATA_W:0]  acc_sum;

	//////////////////////////////////////////////////
	// covox sigma-delta
	//////////////////////////////////////////////////

	// carry out is high V times per 256 cycles
	assign acc_sum = {1'b0, acc} + {1'b0, covox_val};

	always_ff @(posedge fclk) begin
		if (rst) begin
			acc       <= '0;
			acc_carry <= 1'b0;
		end else begin
			acc       <= acc_sum[`ZX_DATA_W-1:0];
			acc_carry <= acc_sum[`ZX_DATA_W];
		end
	end

	//////////////////////////////////////////////////
	// output select
	//////////////////////////////////////////////////

	assign beep = covox_sel ? acc_carry : beep_level;

	assert property (@(posedge fclk) disable iff (rst)
		(!covox_sel && $past(!covox_sel)) |-> (beep == beep_level))
		else $error("beep does not follow beeper level in beeper mode");

endmodule

`default_nettype wire

// ==== verilog/zx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module zx_top import zx_pkg::*; (
	input  logic   fclk,
	input  logic   rst,

	// z80 bus
	input  logic   iorq_n,
	input  logic   mreq_n,
	input  logic   rd_n,
	input  logic   wr_n,
	input  zaddr_t a,
	input  zdata_t din,
	output zdata_t dout,
	output logic   dout_en,

	// memory select
	output page_t  page,
	output logic   romnram,
	output logic   rw_en,

	output logic   beep
);

	logic   iowr_s;
	logic   iord;

	page_t  xt_page0;
	page_t  xt_page1;
	page_t  xt_page2;
	page_t  xt_page3;
	logic   w0_ram;
	logic   w0_we;

	logic   beep_level;
	zdata_t covox_val;
	logic   covox_sel;

	zsignals zsignals (
		.fclk   (fclk),
		.rst    (rst),
		.iorq_n (iorq_n),
		.mreq_n (mreq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.iowr_s (iowr_s),
		.iord   (iord),
		.memrd  ()
	);

	zports zports (
		.fclk       (fclk),
		.rst        (rst),
		.a          (a),
		.din        (din),
		.iowr_s     (iowr_s),
		.iord       (iord),
		.dout       (dout),
		.dout_en    (dout_en),
		.xt_page0   (xt_page0),
		.xt_page1   (xt_page1),
		.xt_page2   (xt_page2),
		.xt_page3   (xt_page3),
		.w0_ram     (w0_ram),
		.w0_we      (w0_we),
		.beep_level (beep_level),
		.covox_val  (covox_val),
		.covox_sel  (covox_sel)
	);

	pager pager (
		.fclk     (fclk),
		.rst      (rst),
		.a        (a),
		.xt_page0 (xt_page0),
		.xt_page1 (xt_page1),
		.xt_page2 (xt_page2),
		.xt_page3 (xt_page3),
		.w0_ram   (w0_ram),
		.w0_we    (w0_we),
		.page     (page),
		.romnram  (romnram),
		.rw_en    (rw_en)
	);

	sound sound (
		.fclk       (fclk),
		.rst        (rst),
		.beep_level (beep_level),
		.covox_val  (covox_val),
		.covox_sel  (covox_sel),
		.beep       (beep)
	);

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic fclk
);

	// 40 ns period
	initial begin
		fclk = 1'b0;
		forever #20 fclk = ~fclk;
	end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "zx_consts.svh"

module tb_top;

	logic        fclk;
	logic        rst;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        dout_en;
	logic [7:0]  page;
	logic        romnram;
	logic        rw_en;
	logic        beep;

	// reference register file
	logic [7:0]  m_page [4];
	logic [7:0]  m_memconf;
	logic        m_beep;
	logic        m_covox_sel;
	int          errors;

	tb_clock clock_gen (.fclk(fclk));

	zx_top DUT (
		.fclk(fclk), .rst(rst), .iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n),
		.wr_n(wr_n), .a(a), .din(din), .dout(dout), .dout_en(dout_en),
		.page(page), .romnram(romnram), .rw_en(rw_en), .beep(beep)
	);

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// model
	//////////////////////////////////////////////////

	// page registers sit at high bytes 10 to 13
	function automatic logic is_page_port(input logic [15:0] ad);
		return ad[7:0] == `ZX_XT_PORT && ad[15:8] >= `ZX_XTPAGE_HI
			&& ad[15:8] <= `ZX_XTPAGE_HI + 8'd3;
	endfunction

	function automatic logic is_memconf_port(input logic [15:0] ad);
		return ad[7:0] == `ZX_XT_PORT && ad[15:8] == `ZX_MEMCONF_HI;
	endfunction

	task automatic model_write(input logic [15:0] ad, input logic [7:0] d);
		if (is_page_port(ad))
			m_page[ad[9:8]] = d;
		if (is_memconf_port(ad))
			m_memconf = d;
		if (ad[7:0] == `ZX_BEEP_PORT) begin
			m_beep = d[`ZX_BEEP_PORT_BIT];
			m_covox_sel = 1'b0;
		end
		if (ad[7:0] == `ZX_COVOX_PORT)
			m_covox_sel = 1'b1;
	endtask

	task automatic check_pager;
		logic [1:0] win;
		logic       rom;
		win = a[15:14];
		rom = (win == 2'd0) && !m_memconf[`ZX_MEMCONF_W0_RAM];
		check("page", 16'(page), 16'(m_page[win]));
		check("romnram", 16'(romnram), 16'(rom));
		check("rw_en", 16'(rw_en), 16'(!(rom && !m_memconf[`ZX_MEMCONF_W0_WE])));
	endtask

	//////////////////////////////////////////////////
	// bus
	//////////////////////////////////////////////////

	// one 6-cycle access, started on the current rising edge
	task automatic bus_access(input logic io, input logic rd, input logic [15:0] ad,
		input logic [7:0] d);
		logic       mapped;
		logic       seen;
		logic [7:0] exp;
		mapped = io && rd && (is_page_port(ad) || is_memconf_port(ad));
		exp = is_page_port(ad) ? m_page[ad[9:8]] : m_memconf;
		seen = 1'b0;
		a <= ad;
		din <= d;
		iorq_n <= !io;
		mreq_n <= io;
		rd_n <= !rd;
		wr_n <= rd;
		for (int i = 0; i < 6; i++) begin
			@(negedge fclk);
			if ((io && rd && !mapped) || !io)
				check("dout_en", 16'(dout_en), 16'd0);
			if (mapped && dout_en && !seen) begin
				seen = 1'b1;
				check("dout", 16'(dout), 16'(exp));
			end
			if (!io && i == 2)
				check_pager();
			@(posedge fclk);
		end
		if (mapped && !seen) begin
			errors++;
			$display("Timeout: dout_en never went high reading port %h", ad);
		end
		if (io && !rd)
			model_write(ad, d);
	endtask

	task automatic idle_gap;
		int gap;
		gap = $urandom_range(1, 4);
		iorq_n <= 1'b1;
		mreq_n <= 1'b1;
		rd_n <= 1'b1;
		wr_n <= 1'b1;
		repeat (gap) begin
			@(negedge fclk);
			check_pager();
			if (!m_covox_sel)
				check("beep", 16'(beep), 16'(m_beep));
			@(posedge fclk);
		end
	endtask

	task automatic io_write(input logic [15:0] ad, input logic [7:0] d);
		bus_access(1'b1, 1'b0, ad, d);
		idle_gap();
	endtask

	task automatic io_read(input logic [15:0] ad);
		bus_access(1'b1, 1'b1, ad, 8'h00);
		idle_gap();
	endtask

	// 0 to 3 are the page registers, 4 is memconf
	function automatic logic [15:0] reg_addr(input int idx);
		if (idx == 4)
			return {`ZX_MEMCONF_HI, `ZX_XT_PORT};
		return {`ZX_XTPAGE_HI + 8'(idx), `ZX_XT_PORT};
	endfunction

	function automatic logic [15:0] unrelated_addr(input logic [31:0] r);
		logic [15:0] ad;
		ad = r[15:0];
		if (r[16])
			ad[7:0] = `ZX_XT_PORT;
		if (ad[7:0] == `ZX_BEEP_PORT || ad[7:0] == `ZX_COVOX_PORT)
			ad[0] = ~ad[0];
		if (is_page_port(ad) || is_memconf_port(ad))
			ad[15:8] = 8'h30;
		return ad;
	endfunction

	task automatic read_all;
		for (int k = 0; k < 5; k++)
			io_read(reg_addr(k));
	endtask

	task automatic count_covox(input logic [7:0] v);
		int highs;
		highs = 0;
		repeat (4) @(posedge fclk);
		repeat (256) begin
			@(negedge fclk);
			if (beep)
				highs++;
			@(posedge fclk);
		end
		check("beep high count", 16'(highs), 16'(v));
	endtask

	initial begin
		logic [31:0] rnd;
		void'($urandom(54028));
		errors = 0;
		rst = 1'b1;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		a = '0;
		din = '0;
		m_page[0] = `ZX_XTPAGE0_RST;
		m_page[1] = `ZX_XTPAGE1_RST;
		m_page[2] = `ZX_XTPAGE2_RST;
		m_page[3] = `ZX_XTPAGE3_RST;
		m_memconf = `ZX_MEMCONF_RST;
		m_beep = 1'b0;
		m_covox_sel = 1'b0;
		repeat (10) @(posedge fclk);
		rst <= 1'b0;
		@(posedge fclk);

		read_all();
		// random writes, each followed by a mapped or random read
		repeat (40) begin
			rnd = $urandom();
			io_write(reg_addr(int'(rnd[10:8]) % 5), rnd[7:0]);
			rnd = $urandom();
			if (rnd[0])
				io_read(reg_addr(int'(rnd[3:1]) % 5));
			else
				io_read(rnd[31:16]);
		end
		// paging on memory reads, memconf changed now and then
		repeat (40) begin
			rnd = $urandom();
			if (rnd[17:16] == 2'd0)
				io_write(reg_addr(4), rnd[31:24]);
			bus_access(1'b0, 1'b1, rnd[15:0], 8'h00);
			idle_gap();
		end
		repeat (8) begin
			rnd = $urandom();
			io_write({rnd[15:8], `ZX_BEEP_PORT}, rnd[23:16]);
		end
		repeat (4) begin
			rnd = $urandom();
			io_write({rnd[15:8], `ZX_COVOX_PORT}, rnd[7:0]);
			count_covox(rnd[7:0]);
		end
		io_write({8'h00, `ZX_BEEP_PORT}, 8'h10);
		repeat (30)
			io_write(unrelated_addr($urandom()), 8'($urandom()));
		read_all();

		$display("tb_top finished with %0d errors", errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/zx_pkg.sv
verilog/zsignals.sv
verilog/zports.sv
verilog/pager.sv
verilog/sound.sv
verilog/zx_top.sv
verif/tb_clock.sv
verif/tb_top.sv

// ==== Makefile ====
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1 || echo "CHECKS FAILED" >> sim.log
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
